//--- src.f
fetch_pkg.sv
fetch_ctrl.sv
fetch_pc.sv
fetch_hold.sv
fetch_imem.sv
fetch_top.sv
fetch_tb.sv

//--- fetch_tb.sv
module fetch_tb;

    import fetch_pkg::*;

    localparam int clk_period   = 10;
    localparam int tb_mem_words = 256;
    localparam int tb_latency   = 2;
    localparam int aw           = $clog2(tb_mem_words);
    localparam int seq_items    = 8;
    localparam int stall_items  = 20;
    // Preload and reset followed by each test in turn
    localparam int budget_cycles = tb_mem_words + 8 + seq_items * tb_latency
                                   + stall_items * (tb_latency + 6) + 60 + 20 + 20 + 40;
    localparam int margin_cycles = 200;

    logic              clk = 1'b0;
    logic              rst_n;
    logic [xlen-1:0]   reset_vector;
    logic              interrupt_pending;
    logic              f2d_valid;
    f2d_type_t         f2d_type;
    logic [xlen-1:0]   f2d_instr;
    logic [xlen-1:0]   f2d_pc;
    cache_resp_t       f2d_resp;
    logic              d2f_ready;
    d2f_cmd_t          d2f_cmd;
    logic [xlen-1:0]   d2f_target;
    logic              dbg_mode;
    logic              dbg_cmd_valid;
    dbg_cmd_t          dbg_cmd;
    logic [xlen-1:0]   dbg_arg;
    logic              dbg_cmd_ready;
    logic [xlen-1:0]   dbg_pc;
    logic              dbg_busy;
    logic              mem_we;
    logic [aw-1:0]     mem_waddr;
    logic [xlen-1:0]   mem_wdata;

    integer            seed = 83926;
    string             test_name = "setup";
    logic [xlen-1:0]   next_pc;
    int                wait_cycles;
    // Copy of the memory contents
    logic [xlen-1:0]   model_mem [tb_mem_words];

    fetch_top #(
        .mem_words   (tb_mem_words),
        .mem_latency (tb_latency)
    ) dut_i (.*);

    always #(clk_period / 2) clk = ~clk;

    // Watchdog over the whole run
    initial begin
        #(clk_period * (budget_cycles + margin_cycles));
        $display("Watchdog expired, the DUT stopped making progress in test %s", test_name);
        stop_run();
    end

    //////////////////////////////////////////////////
    // Reporting and compares
    //////////////////////////////////////////////////

    task automatic stop_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_failure(input string msg);
        $display("%s in test %s", msg, test_name);
        stop_run();
    endtask

    task automatic check_word(input string what, input logic [xlen-1:0] exp,
                              input logic [xlen-1:0] act);
        if (act !== exp) begin
            $display("Error: %s, %s: expected %h, actual %h", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_type(input string what, input f2d_type_t exp, input f2d_type_t act);
        if (act !== exp) begin
            $display("Error: %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    task automatic check_resp(input string what, input cache_resp_t exp, input cache_resp_t act);
        if (act !== exp) begin
            $display("Error: %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
            stop_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Expected memory answers
    //////////////////////////////////////////////////

    // Alignment is checked before range
    function automatic cache_resp_t expected_resp(input logic [xlen-1:0] addr);
        if (addr[1:0] != 2'b00) begin
            return resp_misaligned;
        end
        if (addr[xlen-1:2] >= tb_mem_words) begin
            return resp_access_fault;
        end
        return resp_ok;
    endfunction

    // Faulting fetches return zero data
    function automatic logic [xlen-1:0] expected_word(input logic [xlen-1:0] addr);
        if (expected_resp(addr) != resp_ok) begin
            return '0;
        end
        return model_mem[addr[xlen-1:2]];
    endfunction

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // One cycle of decode inputs with outputs settled on return
    task automatic drive(input logic ready, input d2f_cmd_t cmd, input logic [xlen-1:0] target);
        @(negedge clk);
        d2f_ready  = ready;
        d2f_cmd    = cmd;
        d2f_target = target;
        #1;
    endtask

    task automatic load_memory();
        for (int i = 0; i < tb_mem_words; i++) begin
            @(negedge clk);
            model_mem[i] = $random(seed);
            mem_we       = 1'b1;
            mem_waddr    = aw'(i);
            mem_wdata    = model_mem[i];
        end
        @(negedge clk);
        mem_we = 1'b0;
    endtask

    // Four cycles of reset once the memory holds its code
    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (3) @(negedge clk);
        #1;
        if (f2d_valid !== 1'b0 || dbg_cmd_ready !== 1'b0 || dbg_busy !== 1'b1) begin
            report_failure("Outputs are not at their reset values");
        end
        @(negedge clk);
        rst_n   = 1'b1;
        next_pc = reset_vector;
    endtask

    // Wait for the next item with decode ready and check it against the copy
    task automatic expect_next();
        int waited;
        waited = 1;
        drive(1'b1, d2f_none, '0);
        while (!f2d_valid) begin
            drive(1'b1, d2f_none, '0);
            waited++;
        end
        wait_cycles = waited;
        check_type("f2d_type", fetch_pkg::f2d_instr, f2d_type);
        check_word("f2d_pc", next_pc, f2d_pc);
        check_word("f2d_instr", expected_word(next_pc), f2d_instr);
        check_resp("f2d_resp", expected_resp(next_pc), f2d_resp);
        next_pc = next_pc + 32'd4;
    endtask

    // Offered item must not move during a random stall
    task automatic expect_stalled();
        int              stall;
        logic            offered;
        logic [xlen-1:0] held_pc;
        logic [xlen-1:0] held_instr;
        stall   = {$random(seed)} % 6;
        offered = 1'b0;
        repeat (stall) begin
            drive(1'b0, d2f_none, '0);
            if (offered) begin
                if (!f2d_valid) begin
                    report_failure("Offered item was withdrawn under back-pressure");
                end
                check_word("held f2d_pc", held_pc, f2d_pc);
                check_word("held f2d_instr", held_instr, f2d_instr);
            end else if (f2d_valid) begin
                offered    = 1'b1;
                held_pc    = f2d_pc;
                held_instr = f2d_instr;
                check_word("stalled f2d_pc", next_pc, f2d_pc);
            end
        end
        expect_next();
    endtask

    // Called right after an accepted item while a fetch is in flight
    task automatic redirect_to(input d2f_cmd_t cmd, input logic [xlen-1:0] target);
        drive(1'b1, cmd, target);
        if (f2d_valid) begin
            report_failure("An item was offered in the redirect cycle");
        end
        next_pc = target;
    endtask

    task automatic debug_command(input dbg_cmd_t cmd, input logic [xlen-1:0] arg,
                                 output logic [xlen-1:0] pc_seen);
        @(negedge clk);
        dbg_cmd_valid = 1'b1;
        dbg_cmd       = cmd;
        dbg_arg       = arg;
        #1;
        while (!dbg_cmd_ready) begin
            @(negedge clk);
            #1;
        end
        pc_seen = dbg_pc;
        // Ready must drop while valid is still high
        @(negedge clk);
        #1;
        if (dbg_cmd_ready) begin
            report_failure("dbg_cmd_ready stayed high for more than one cycle");
        end
        @(negedge clk);
        dbg_cmd_valid = 1'b0;
        dbg_cmd       = dbg_none;
        #1;
    endtask

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_sequential();
        test_name = "sequential";
        for (int i = 0; i < seq_items; i++) begin
            expect_next();
            // One item per memory latency including the first
            check_word("item spacing", tb_latency, wait_cycles);
        end
    endtask

    task automatic test_back_pressure();
        test_name = "back_pressure";
        repeat (stall_items) expect_stalled();
    endtask

    task automatic test_branch_faults();
        test_name = "branch_faults";
        redirect_to(d2f_branch, 32'h0000_0200);
        repeat (2) expect_next();
        redirect_to(d2f_branch, 32'h0000_0102);
        expect_next();
        // Last two words and the first address past the memory
        redirect_to(d2f_branch, 32'h0000_03f8);
        repeat (3) expect_next();
        redirect_to(d2f_branch, 32'h0000_0800);
        expect_next();
    endtask

    task automatic test_flush();
        test_name = "flush";
        redirect_to(d2f_flush, 32'h0000_0120);
        repeat (3) expect_next();
    endtask

    task automatic test_interrupt();
        test_name = "interrupt";
        @(negedge clk);
        interrupt_pending = 1'b1;
        d2f_cmd           = d2f_none;
        #1;
        // Fetch in flight is still delivered
        expect_next();
        drive(1'b1, d2f_none, '0);
        while (!f2d_valid) begin
            drive(1'b1, d2f_none, '0);
        end
        check_type("marker f2d_type", f2d_interrupt, f2d_type);
        @(negedge clk);
        interrupt_pending = 1'b0;
        d2f_cmd           = d2f_branch;
        d2f_target        = 32'h0000_0300;
        #1;
        next_pc = 32'h0000_0300;
        repeat (2) expect_next();
    endtask

    task automatic test_debug();
        logic [xlen-1:0] pc_seen;
        test_name = "debug";
        @(negedge clk);
        dbg_mode = 1'b1;
        d2f_cmd  = d2f_none;
        #1;
        expect_next();
        while (dbg_busy) begin
            drive(1'b1, d2f_none, '0);
            if (f2d_valid) begin
                report_failure("An item was offered in debug mode");
            end
        end
        repeat (4) begin
            drive(1'b1, d2f_none, '0);
            if (f2d_valid || dbg_busy) begin
                report_failure("Fetch did not stay idle in debug mode");
            end
        end
        debug_command(dbg_read_pc, '0, pc_seen);
        check_word("dbg_pc", next_pc, pc_seen);
        debug_command(dbg_jump, 32'h0000_0180, pc_seen);
        debug_command(dbg_read_pc, '0, pc_seen);
        check_word("dbg_pc after jump", 32'h0000_0180, pc_seen);
        @(negedge clk);
        dbg_mode = 1'b0;
        #1;
        next_pc = 32'h0000_0180;
        repeat (2) expect_next();
    endtask

    initial begin
        rst_n             = 1'b1;
        reset_vector      = 32'h0000_0040;
        interrupt_pending = 1'b0;
        d2f_ready         = 1'b1;
        d2f_cmd           = d2f_none;
        d2f_target        = '0;
        dbg_mode          = 1'b0;
        dbg_cmd_valid     = 1'b0;
        dbg_cmd           = dbg_none;
        dbg_arg           = '0;
        mem_we            = 1'b0;
        mem_waddr         = '0;
        mem_wdata         = '0;
        load_memory();
        apply_reset();
        test_sequential();
        test_back_pressure();
        test_branch_faults();
        test_flush();
        test_interrupt();
        test_debug();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- fetch_top.sv
module fetch_top #(
    parameter int mem_words   = 256,
    parameter int mem_latency = 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [fetch_pkg::xlen-1:0]      reset_vector,
    input  logic                            interrupt_pending,
    // Decode
    output logic                            f2d_valid,
    output fetch_pkg::f2d_type_t            f2d_type,
    output logic [fetch_pkg::xlen-1:0]      f2d_instr,
    output logic [fetch_pkg::xlen-1:0]      f2d_pc,
    output fetch_pkg::cache_resp_t          f2d_resp,
    input  logic                            d2f_ready,
    input  fetch_pkg::d2f_cmd_t             d2f_cmd,
    input  logic [fetch_pkg::xlen-1:0]      d2f_target,
    // Debug
    input  logic                            dbg_mode,
    input  logic                            dbg_cmd_valid,
    input  fetch_pkg::dbg_cmd_t             dbg_cmd,
    input  logic [fetch_pkg::xlen-1:0]      dbg_arg,
    output logic                            dbg_cmd_ready,
    output logic [fetch_pkg::xlen-1:0]      dbg_pc,
    output logic                            dbg_busy,
    // Memory preload
    input  logic                            mem_we,
    input  logic [$clog2(mem_words)-1:0]    mem_waddr,
    input  logic [fetch_pkg::xlen-1:0]      mem_wdata
);

    import fetch_pkg::*;

    // Memory bus
    cache_cmd_t        c_cmd;
    logic [xlen-1:0]   c_address;
    logic              c_done;
    cache_resp_t       c_response;
    logic [xlen-1:0]   c_load_data;
    // PC block
    cache_cmd_t        active_cmd;
    logic [xlen-1:0]   pc;
    logic              pc_load;
    logic [xlen-1:0]   pc_next;
    logic              redirect_pending;
    logic [xlen-1:0]   redirect_target_q;
    logic              redirect_set;
    logic              redirect_clear;
    logic [xlen-1:0]   redirect_target;
    logic              flush_pending;
    logic              flush_set;
    logic              flush_clear;
    // Hold buffer
    logic              hold_valid;
    logic [xlen-1:0]   hold_instr;
    cache_resp_t       hold_resp;
    logic              hold_load;
    logic              hold_clear;

    fetch_ctrl ctrl_i (.*);

    fetch_pc pc_i (.*);

    fetch_hold hold_i (.*);

    fetch_imem #(
        .mem_words   (mem_words),
        .mem_latency (mem_latency)
    ) imem_i (.*);

endmodule

//--- fetch_imem.sv
module fetch_imem #(
    parameter int mem_words   = 256,
    parameter int mem_latency = 2
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  fetch_pkg::cache_cmd_t           c_cmd,
    input  logic [fetch_pkg::xlen-1:0]      c_address,
    input  logic                            mem_we,
    input  logic [$clog2(mem_words)-1:0]    mem_waddr,
    input  logic [fetch_pkg::xlen-1:0]      mem_wdata,
    output logic                            c_done,
    output fetch_pkg::cache_resp_t          c_response,
    output logic [fetch_pkg::xlen-1:0]      c_load_data
);

    import fetch_pkg::*;

    localparam int aw    = $clog2(mem_words);
    localparam int cnt_w = $clog2(mem_latency + 1);

    logic [xlen-1:0]   mem [mem_words];
    logic [cnt_w-1:0]  cnt;
    logic [cnt_w-1:0]  seen;
    logic [cnt_w-1:0]  need;
    logic [xlen-3:0]   word_addr;
    logic              misaligned;
    logic              in_range;

    // Load port for preloading code
    always_ff @(posedge clk) begin
        if (mem_we) begin
            mem[mem_waddr] <= mem_wdata;
        end
    end

    //////////////////////////////////////////////////
    // Latency counter
    //////////////////////////////////////////////////

    // Cycles the command has been presented, this one included
    assign seen = cnt + cnt_w'(1);
    // Flush finishes after one cycle
    assign need = (c_cmd == cmd_flush_all) ? cnt_w'(1) : cnt_w'(mem_latency);

    assign word_addr  = c_address[xlen-1:2];
    assign misaligned = (c_address[1:0] != 2'b00);
    assign in_range   = (word_addr < (xlen-2)'(mem_words));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt    <= '0;
            c_done <= 1'b0;
        end else begin
            c_done <= 1'b0;
            if (c_cmd == cmd_none) begin
                cnt <= '0;
            end else if (seen == need) begin
                // Counter restarts, next command may follow in the done cycle
                cnt    <= '0;
                c_done <= 1'b1;
            end else begin
                cnt <= seen;
            end
        end
    end

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if ((c_cmd != cmd_none) && (seen == need)) begin
            c_response  <= resp_ok;
            c_load_data <= '0;
            if (c_cmd == cmd_execute) begin
                if (misaligned) begin
                    c_response <= resp_misaligned;
                end else if (!in_range) begin
                    c_response <= resp_access_fault;
                end else begin
                    c_load_data <= mem[word_addr[aw-1:0]];
                end
            end
        end
    end

endmodule

//--- fetch_hold.sv
module fetch_hold (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          hold_load,
    input  logic                          hold_clear,
    input  logic [fetch_pkg::xlen-1:0]    c_load_data,
    input  fetch_pkg::cache_resp_t        c_response,
    output logic                          hold_valid,
    output logic [fetch_pkg::xlen-1:0]    hold_instr,
    output fetch_pkg::cache_resp_t        hold_resp
);

    // Valid bit, cleared once decode takes the word
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_valid <= 1'b0;
        end else if (hold_load) begin
            hold_valid <= 1'b1;
        end else if (hold_clear) begin
            hold_valid <= 1'b0;
        end
    end

    // Word and response from the completing fetch
    always_ff @(posedge clk) begin
        if (hold_load) begin
            hold_instr <= c_load_data;
            hold_resp  <= c_response;
        end
    end

endmodule

//--- fetch_pc.sv
module fetch_pc (
    input  logic                          clk,
    input  logic                          rst_n,
    input  fetch_pkg::cache_cmd_t         c_cmd,
    input  logic                          pc_load,
    input  logic [fetch_pkg::xlen-1:0]    pc_next,
    input  logic                          redirect_set,
    input  logic                          redirect_clear,
    input  logic [fetch_pkg::xlen-1:0]    redirect_target,
    input  logic                          flush_set,
    input  logic                          flush_clear,
    output logic [fetch_pkg::xlen-1:0]    pc,
    output fetch_pkg::cache_cmd_t         active_cmd,
    output logic                          redirect_pending,
    output logic [fetch_pkg::xlen-1:0]    redirect_target_q,
    output logic                          flush_pending
);

    import fetch_pkg::*;

    //////////////////////////////////////////////////
    // Control flags
    //////////////////////////////////////////////////

    // Reset leaves a redirect pending so the first fetch goes to the reset vector
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active_cmd       <= cmd_none;
            redirect_pending <= 1'b1;
            flush_pending    <= 1'b0;
        end else begin
            active_cmd <= c_cmd;
            // Set wins, a new redirect may come in the cycle the old one is used
            if (redirect_set) begin
                redirect_pending <= 1'b1;
            end else if (redirect_clear) begin
                redirect_pending <= 1'b0;
            end
            if (flush_set) begin
                flush_pending <= 1'b1;
            end else if (flush_clear) begin
                flush_pending <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Addresses
    //////////////////////////////////////////////////

    // Address of the command in flight, or of the last one
    always_ff @(posedge clk) begin
        if (pc_load) begin
            pc <= pc_next;
        end
    end

    // Target is taken from the control block during reset too
    always_ff @(posedge clk) begin
        if (!rst_n || redirect_set) begin
            redirect_target_q <= redirect_target;
        end
    end

endmodule

//--- fetch_ctrl.sv
module fetch_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [fetch_pkg::xlen-1:0]    reset_vector,
    // Memory side
    input  logic                          c_done,
    input  fetch_pkg::cache_resp_t        c_response,
    input  logic [fetch_pkg::xlen-1:0]    c_load_data,
    output fetch_pkg::cache_cmd_t         c_cmd,
    output logic [fetch_pkg::xlen-1:0]    c_address,
    // State from the PC block
    input  fetch_pkg::cache_cmd_t         active_cmd,
    input  logic [fetch_pkg::xlen-1:0]    pc,
    input  logic                          redirect_pending,
    input  logic [fetch_pkg::xlen-1:0]    redirect_target_q,
    input  logic                          flush_pending,
    output logic                          pc_load,
    output logic [fetch_pkg::xlen-1:0]    pc_next,
    output logic                          redirect_set,
    output logic                          redirect_clear,
    output logic [fetch_pkg::xlen-1:0]    redirect_target,
    output logic                          flush_set,
    output logic                          flush_clear,
    // Hold buffer
    input  logic                          hold_valid,
    input  logic [fetch_pkg::xlen-1:0]    hold_instr,
    input  fetch_pkg::cache_resp_t        hold_resp,
    output logic                          hold_load,
    output logic                          hold_clear,
    input  logic                          interrupt_pending,
    // Decode side
    output logic                          f2d_valid,
    output fetch_pkg::f2d_type_t          f2d_type,
    output logic [fetch_pkg::xlen-1:0]    f2d_instr,
    output logic [fetch_pkg::xlen-1:0]    f2d_pc,
    output fetch_pkg::cache_resp_t        f2d_resp,
    input  logic                          d2f_ready,
    input  fetch_pkg::d2f_cmd_t           d2f_cmd,
    input  logic [fetch_pkg::xlen-1:0]    d2f_target,
    // Debug side
    input  logic                          dbg_mode,
    input  logic                          dbg_cmd_valid,
    input  fetch_pkg::dbg_cmd_t           dbg_cmd,
    input  logic [fetch_pkg::xlen-1:0]    dbg_arg,
    output logic                          dbg_cmd_ready,
    output logic [fetch_pkg::xlen-1:0]    dbg_pc,
    output logic                          dbg_busy
);

    import fetch_pkg::*;

    logic              active;
    logic              d2f_branch_now;
    logic              d2f_flush_now;
    logic              flushing;
    logic              branching;
    logic [xlen-1:0]   branching_target;
    logic [xlen-1:0]   pc_plus_4;
    logic              record_d2f;
    logic              record_dbg;
    logic              dbg_ack_q;

    assign active         = (active_cmd != cmd_none);
    assign d2f_branch_now = d2f_ready && (d2f_cmd == d2f_branch);
    assign d2f_flush_now  = d2f_ready && (d2f_cmd == d2f_flush);
    assign flushing       = flush_pending || d2f_flush_now;
    assign branching      = redirect_pending || d2f_branch_now;
    // A branch seen this cycle wins over the stored one
    assign branching_target = d2f_branch_now ? d2f_target : redirect_target_q;
    assign pc_plus_4 = pc + xlen'(4);

    // Next fetch address as seen by the debugger
    assign dbg_pc = redirect_pending ? redirect_target_q : pc_plus_4;

    // Last cycle acknowledged a debug command, keeps ready a single pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dbg_ack_q <= 1'b0;
        end else begin
            dbg_ack_q <= dbg_cmd_ready;
        end
    end

    always_comb begin
        c_cmd           = active_cmd;
        c_address       = pc;
        f2d_valid       = 1'b0;
        f2d_type        = fetch_pkg::f2d_instr;
        f2d_instr       = c_load_data;
        f2d_pc          = pc;
        f2d_resp        = c_response;
        redirect_set    = 1'b0;
        redirect_clear  = 1'b0;
        redirect_target = d2f_target;
        flush_set       = 1'b0;
        flush_clear     = 1'b0;
        hold_load       = 1'b0;
        hold_clear      = 1'b0;
        dbg_cmd_ready   = 1'b0;
        dbg_busy        = 1'b1;
        record_d2f      = 1'b0;
        record_dbg      = 1'b0;

        if (!rst_n) begin
            // Reset vector becomes the pending redirect in the PC block
            c_cmd           = cmd_none;
            c_address       = reset_vector;
            redirect_target = reset_vector;
        end else begin
            //////////////////////////////////////////////////
            // Item offered to decode
            //////////////////////////////////////////////////
            if (hold_valid) begin
                f2d_valid = 1'b1;
                f2d_instr = hold_instr;
                f2d_resp  = hold_resp;
            end else if (c_done && (active_cmd == cmd_execute)) begin
                // Fetch in flight was overtaken by a redirect, drop it
                f2d_valid = !redirect_pending;
                hold_load = !d2f_ready && !redirect_pending;
            end else if (!active && interrupt_pending) begin
                f2d_valid = 1'b1;
                f2d_type  = f2d_interrupt;
            end

            //////////////////////////////////////////////////
            // Next memory command
            //////////////////////////////////////////////////
            if (hold_valid && !d2f_ready) begin
                // Stalled on a held word
                c_cmd = cmd_none;
            end else if (!active || hold_valid || (c_done && (d2f_ready || !f2d_valid))) begin
                // Held word taken this cycle
                hold_clear = hold_valid;
                if (dbg_mode) begin
                    c_cmd      = cmd_none;
                    dbg_busy   = active;
                    record_d2f = 1'b1;
                    record_dbg = !active;
                end else if (interrupt_pending) begin
                    // Keep branches that arrive while the marker is shown
                    c_cmd      = cmd_none;
                    record_d2f = 1'b1;
                end else if (flushing) begin
                    c_cmd       = cmd_flush_all;
                    flush_clear = 1'b1;
                    if (d2f_flush_now) begin
                        redirect_set = 1'b1;
                    end
                end else if (branching) begin
                    c_cmd          = cmd_execute;
                    c_address      = branching_target;
                    redirect_clear = 1'b1;
                end else begin
                    c_cmd     = cmd_execute;
                    c_address = pc_plus_4;
                end
            end else if (active && !c_done) begin
                // Command stays put until done, remember redirects meanwhile
                c_cmd      = active_cmd;
                record_d2f = 1'b1;
            end else begin
                c_cmd = cmd_none;
            end

            if (record_d2f) begin
                if (d2f_flush_now) begin
                    flush_set    = 1'b1;
                    redirect_set = 1'b1;
                end else if (d2f_branch_now) begin
                    redirect_set = 1'b1;
                end
            end

            // Debug jump overrides any decode target of the same cycle
            if (record_dbg && dbg_cmd_valid && !dbg_ack_q) begin
                dbg_cmd_ready = 1'b1;
                if (dbg_cmd == dbg_jump) begin
                    redirect_set    = 1'b1;
                    redirect_target = dbg_arg;
                end
            end
        end

        // PC follows every presented command
        pc_load = (c_cmd != cmd_none) || !rst_n;
        pc_next = c_address;
    end

endmodule

//--- fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // Data and address width
    localparam int xlen = 32;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // Command toward the instruction memory
    typedef enum logic [1:0] {
        cmd_none      = 2'd0,
        cmd_execute   = 2'd1,
        cmd_flush_all = 2'd2
    } cache_cmd_t;

    // Memory response, valid together with c_done
    typedef enum logic [1:0] {
        resp_ok           = 2'd0,
        resp_misaligned   = 2'd1,
        resp_access_fault = 2'd2
    } cache_resp_t;

    // Command from decode, only counted while d2f_ready is high
    typedef enum logic [1:0] {
        d2f_none   = 2'd0,
        d2f_branch = 2'd1,
        d2f_flush  = 2'd2
    } d2f_cmd_t;

    // Kind of item offered to decode
    typedef enum logic {
        f2d_instr     = 1'b0,
        f2d_interrupt = 1'b1
    } f2d_type_t;

    // Debug commands
    typedef enum logic [1:0] {
        dbg_none    = 2'd0,
        dbg_jump    = 2'd1,
        dbg_read_pc = 2'd2,
        dbg_other   = 2'd3
    } dbg_cmd_t;

endpackage
